// ==== bench/issue_patterns.hex ====
// Inputs: test icache_valid pair pc irin({second,first}) plv excp stall flush
// Expected: issue0_valid issue1_valid issue0_pc issue1_pc full; test FF ends the list
1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 0 1000 0000000000100C41 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 1 0 1000 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0
// Independent pair, then a pair with a RAW hazard on r1
2 1 1 2000 001018A400100C41 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 1 1 2000 2004 0
2 1 1 3000 0010082700100C41 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 1 0 3000 0 0
2 0 0 0 0 0 0 0 0 1 0 3004 0 0
// Branch and csr in lane0, load plus store, exception argument
3 1 1 4000 00100C41580001EE 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 1 0 4000 0 0
3 1 1 5000 00100C4104000010 0 0 0 0 1 0 4004 0 0
3 1 1 6000 298001AC2880016A 0 0 0 0 1 0 5000 0 0
3 1 0 7000 000000002880016A 0 0 0 0 1 1 5004 6000 0
3 1 1 8000 001018A402801528 0 1 0 0 1 0 6004 0 0
3 0 0 0 0 0 0 0 0 1 0 7000 0 0
3 0 0 0 0 0 0 0 0 1 0 8000 0 0
3 0 0 0 0 0 0 0 0 1 0 8004 0 0
// Fill under stall until full, then drain
4 1 1 9000 001018A400100C41 0 0 1 0 0 0 0 0 0
4 1 1 9008 001018A400100C41 0 0 1 0 0 0 0 0 0
4 1 1 9010 001018A400100C41 0 0 1 0 0 0 0 0 0
4 1 1 9018 001018A400100C41 0 0 1 0 0 0 0 0 0
4 1 1 9020 001018A400100C41 0 0 1 0 0 0 0 0 0
4 1 1 9028 001018A400100C41 0 0 1 0 0 0 0 0 0
4 1 1 9030 001018A400100C41 0 0 1 0 0 0 0 0 0
4 0 0 0 0 0 0 1 0 0 0 0 0 1
4 0 0 0 0 0 0 0 0 1 1 9000 9004 1
4 0 0 0 0 0 0 0 0 1 1 9008 900C 0
4 0 0 0 0 0 0 0 0 1 1 9010 9014 0
4 0 0 0 0 0 0 0 0 1 1 9018 901C 0
4 0 0 0 0 0 0 0 0 1 1 9020 9024 0
4 0 0 0 0 0 0 0 0 1 1 9028 902C 0
4 0 0 0 0 0 0 0 0 1 1 9030 9034 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0
// Flush drops queued entries
5 1 1 A000 001018A400100C41 0 0 1 0 0 0 0 0 0
5 1 0 A008 0000000000100C41 0 0 1 0 0 0 0 0 0
5 0 0 0 0 0 0 1 1 0 0 0 0 0
5 1 1 B000 001018A400100C41 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 1 1 B000 B004 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0
FF 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== flist.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/decode_pkg.sv
hdl/fetch_if.sv
hdl/fetch_buffer.sv
hdl/instr_predecode.sv
hdl/issue_pairer.sv
hdl/fetch_decode_top.sv
bench/fetch_decode_sva.sv
bench/fetch_decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_decode_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/fetch_decode_tb.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_decode_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_fields = 14;  // Words per pattern row
    localparam int max_rows = 64;

    typedef struct {
        logic [31:0]        instr;
        logic [1:0]         plv;
        logic [`PRED_W-1:0] pred;
        logic [`EXCP_W-1:0] excp;
    } sent_t;

    logic                clk;
    logic                rstn;
    logic                flush;
    logic                stall;
    logic                icache_valid;
    logic                pair;
    logic [31:0]         pc;
    logic [63:0]         irin;
    logic [1:0]          plv;
    logic [`PRED_W-1:0]  pred;
    logic [`EXCP_W-1:0]  excp;
    logic                full;
    logic                issue0_valid;
    logic [31:0]         issue0_pc;
    logic [31:0]         issue0_instr;
    logic [1:0]          issue0_plv;
    logic [`PRED_W-1:0]  issue0_pred;
    logic [`EXCP_W-1:0]  issue0_excp;
    logic                issue1_valid;
    logic [31:0]         issue1_pc;
    logic [31:0]         issue1_instr;
    logic [1:0]          issue1_plv;
    logic [`PRED_W-1:0]  issue1_pred;
    logic [`EXCP_W-1:0]  issue1_excp;

    logic [63:0] pat [max_rows * n_fields];
    sent_t       sent [logic [31:0]];  // What each strobe delivered, by pc
    int          n_rows;
    bit          rows_ready;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    fetch_decode_top dut_i (
        .clk (clk), .rstn (rstn), .flush (flush), .stall (stall),
        .icache_valid (icache_valid), .pair (pair), .pc (pc), .irin (irin),
        .plv (plv), .pred (pred), .excp (excp), .full (full),
        .issue0_valid (issue0_valid), .issue0_pc (issue0_pc), .issue0_instr (issue0_instr),
        .issue0_plv (issue0_plv), .issue0_pred (issue0_pred), .issue0_excp (issue0_excp),
        .issue1_valid (issue1_valid), .issue1_pc (issue1_pc), .issue1_instr (issue1_instr),
        .issue1_plv (issue1_plv), .issue1_pred (issue1_pred), .issue1_excp (issue1_excp)
    );

    always #50 clk = ~clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    // Each row holds the test id, the strobe fields, stall and flush, then the expected values
    task automatic apply_row(input int b);
        icache_valid = pat[b + 1][0];
        pair         = pat[b + 2][0];
        pc           = pat[b + 3][31:0];
        irin         = pat[b + 4];
        plv          = pat[b + 5][1:0];
        excp         = pat[b + 6][`EXCP_W-1:0];
        stall        = pat[b + 7][0];
        flush        = pat[b + 8][0];
        pred         = {$random(seed), $random(seed)};
        if (icache_valid) begin
            sent[pc] = '{irin[31:0], plv, pred, excp};
            if (pair) begin
                sent[pc + 32'd4] = '{irin[63:32], plv, pred, '0};  // Second word has no exception
            end
        end
    endtask

    task automatic check_entry(input logic [31:0] exp_pc, input logic [31:0] instr,
                               input logic [1:0] lvl, input logic [`PRED_W-1:0] pw,
                               input logic [`EXCP_W-1:0] ex, input string lane);
        sent_t s;
        if (!sent.exists(exp_pc)) begin
            $display("[ERROR] t=%0d ns: no strobe delivered pc %h", $time, exp_pc);
            test_errs++;
        end else begin
            s = sent[exp_pc];
            check_value(instr, s.instr, {lane, "_instr"});
            check_value(lvl, s.plv, {lane, "_plv"});
            check_value(pw, s.pred, {lane, "_pred"});
            check_value(ex, s.excp, {lane, "_excp"});
        end
    endtask

    task automatic check_row(input int b);
        check_value({31'd0, issue0_valid}, pat[b + 9][31:0], "issue0_valid");
        check_value({31'd0, issue1_valid}, pat[b + 10][31:0], "issue1_valid");
        if (pat[b + 9][0]) begin
            check_value(issue0_pc, pat[b + 11][31:0], "issue0_pc");
            check_entry(pat[b + 11][31:0], issue0_instr, issue0_plv, issue0_pred,
                        issue0_excp, "issue0");
        end
        if (pat[b + 10][0]) begin
            check_value(issue1_pc, pat[b + 12][31:0], "issue1_pc");
            check_entry(pat[b + 12][31:0], issue1_instr, issue1_plv, issue1_pred,
                        issue1_excp, "issue1");
        end
        check_value({31'd0, full}, pat[b + 13][31:0], "full");
    endtask

    task automatic close_test(input int id);
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0d passed", id);
        end else begin
            $display("Test %0d failed with %0d errors", id, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        wait (rows_ready);
        #(n_rows * 100 + 20 * 100);
        $display("Watchdog expired before the last pattern row was checked");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        seed = 32'hc802;
        icache_valid = 1'b0;
        pair = 1'b0;
        pc = '0;
        irin = '0;
        plv = '0;
        pred = '0;
        excp = '0;
        stall = 1'b0;
        flush = 1'b0;
        $readmemh("bench/issue_patterns.hex", pat);
        n_rows = 0;
        while (n_rows < max_rows && pat[n_rows * n_fields] != 64'hff) begin
            n_rows++;
        end
        rows_ready = 1'b1;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r * n_fields);
            #40;  // Just ahead of the next rising edge
            check_row(r * n_fields);
            if (pat[(r + 1) * n_fields] != pat[r * n_fields]) begin
                close_test(int'(pat[r * n_fields][7:0]));
            end
            @(negedge clk);
        end
        total_errs += dut_i.buffer_i.sva_i.fail_count;
        if (tests_run == 0) begin
            $display("No pattern rows were read from bench/issue_patterns.hex");
        end
        $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
        if (total_errs == 0 && tests_run > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/fetch_decode_sva.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_decode_sva (
    input wire logic                 clk,
    input wire logic                 rstn,
    input wire logic [`FB_CNT_W-1:0] count,
    input wire logic                 full,
    input wire logic                 icache_valid,
    input wire logic                 take0,
    input wire logic                 take1
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Assertion failures seen so far

    count_in_range: assert property (@(posedge clk) disable iff (!rstn)
        count <= `FB_CNT_W'(`FB_DEPTH))
        else begin
            $error("buffer count %0d is above the depth", count);
            fail_count++;
        end

    // Upstream has to honour the full hint
    no_strobe_when_full: assert property (@(posedge clk) disable iff (!rstn)
        full |-> !icache_valid)
        else begin
            $error("cache strobe arrived while the buffer was full");
            fail_count++;
        end

    second_needs_first: assert property (@(posedge clk) disable iff (!rstn)
        take1 |-> take0)
        else begin
            $error("take1 high without take0");
            fail_count++;
        end

endmodule

bind fetch_buffer fetch_decode_sva sva_i (
    .clk          (clk),
    .rstn         (rstn),
    .count        (count),
    .full         (full),
    .icache_valid (icache_valid),
    .take0        (take0),
    .take1        (take1)
);

`default_nettype wire

// ==== hdl/fetch_decode_top.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_decode_top (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 flush,
    input  wire logic                 stall,
    input  wire logic                 icache_valid,
    input  wire logic                 pair,
    input  wire logic [31:0]          pc,
    input  wire logic [63:0]          irin,
    input  wire logic [1:0]           plv,
    input  wire logic [`PRED_W-1:0]   pred,
    input  wire logic [`EXCP_W-1:0]   excp,
    output logic                      full,
    output logic                      issue0_valid,
    output logic [31:0]               issue0_pc,
    output logic [31:0]               issue0_instr,
    output logic [1:0]                issue0_plv,
    output logic [`PRED_W-1:0]        issue0_pred,
    output logic [`EXCP_W-1:0]        issue0_excp,
    output logic                      issue1_valid,
    output logic [31:0]               issue1_pc,
    output logic [31:0]               issue1_instr,
    output logic [1:0]                issue1_plv,
    output logic [`PRED_W-1:0]        issue1_pred,
    output logic [`EXCP_W-1:0]        issue1_excp
);

    fb_slot_if   slot0_if ();
    fb_slot_if   slot1_if ();
    lane_info_if info0_if ();
    lane_info_if info1_if ();

    logic take0;
    logic take1;

    fetch_buffer buffer_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .icache_valid (icache_valid),
        .pair         (pair),
        .pc           (pc),
        .irin         (irin),
        .plv          (plv),
        .pred         (pred),
        .excp         (excp),
        .take0        (take0),
        .take1        (take1),
        .full         (full),
        .slot0        (slot0_if),
        .slot1        (slot1_if)
    );

    instr_predecode lane0_i (.slot(slot0_if), .info(info0_if));
    instr_predecode lane1_i (.slot(slot1_if), .info(info1_if));

    issue_pairer pairer_i (
        .stall (stall),
        .lane0 (info0_if),
        .lane1 (info1_if),
        .take0 (take0),
        .take1 (take1)
    );

    assign issue0_valid = take0;
    assign issue0_pc    = slot0_if.entry.pc;
    assign issue0_instr = slot0_if.entry.instr;
    assign issue0_plv   = slot0_if.entry.plv;
    assign issue0_pred  = slot0_if.entry.pred;
    assign issue0_excp  = slot0_if.entry.excp;

    assign issue1_valid = take1;
    assign issue1_pc    = slot1_if.entry.pc;
    assign issue1_instr = slot1_if.entry.instr;
    assign issue1_plv   = slot1_if.entry.plv;
    assign issue1_pred  = slot1_if.entry.pred;
    assign issue1_excp  = slot1_if.entry.excp;

endmodule

`default_nettype wire

// ==== hdl/issue_pairer.sv ====
`default_nettype none

module issue_pairer
    import decode_pkg::*;
(
    input  wire logic       stall,
    lane_info_if.consumer   lane0,
    lane_info_if.consumer   lane1,
    output logic            take0,
    output logic            take1
);

    lane_info_t i0;
    lane_info_t i1;
    logic       lane0_ends_group;
    logic       any_excp;
    logic       raw_hazard;
    logic       mem_conflict;
    logic       block_pair;

    assign i0 = lane0.info;
    assign i1 = lane1.info;

    assign lane0_ends_group = (i0.cls == cls_branch) || (i0.cls == cls_priv);
    assign any_excp         = i0.has_excp || i1.has_excp;

    // Lane1 cannot see lane0's result in the same cycle
    assign raw_hazard = (i0.dst != 5'd0) &&
                        ((i1.src1 == i0.dst) || (i1.src2 == i0.dst));

    // Single memory port
    assign mem_conflict = ((i0.cls == cls_load) || (i0.cls == cls_store)) &&
                          ((i1.cls == cls_load) || (i1.cls == cls_store));

    assign block_pair = lane0_ends_group || any_excp || (i1.cls == cls_priv) ||
                        raw_hazard || mem_conflict;

    assign take0 = lane0.valid && !stall;
    assign take1 = take0 && lane1.valid && !block_pair;

endmodule

`default_nettype wire

// ==== hdl/instr_predecode.sv ====
`default_nettype none

module instr_predecode
    import fetch_pkg::*;
    import decode_pkg::*;
(
    fb_slot_if.consumer    slot,
    lane_info_if.producer  info
);

    fb_entry_t    ent;
    instr_word_u  iw;
    instr_class_e cls;
    lane_info_t   res;

    assign ent = slot.entry;
    assign iw  = ent.instr;

    always_comb begin
        if (iw.r3.opcode == op_add_w || iw.r3.opcode == op_sub_w) begin
            cls = cls_alu3r;
        end else if (iw.ri12.opcode == op_addi_w) begin
            cls = cls_alui12;
        end else if (iw.ri12.opcode == op_ld_w) begin
            cls = cls_load;
        end else if (iw.ri12.opcode == op_st_w) begin
            cls = cls_store;
        end else if (iw.ri12.opcode[9:4] == op_beq) begin
            cls = cls_branch;
        end else if (iw.ri12.opcode[9:2] == op_csr) begin
            cls = cls_priv;
        end else begin
            cls = cls_other;
        end
    end

    always_comb begin
        res          = '0;
        res.cls      = cls;
        res.has_excp = |ent.excp;
        case (cls)
            cls_alu3r: begin
                res.src1 = iw.r3.rj;
                res.src2 = iw.r3.rk;
                res.dst  = iw.r3.rd;
            end
            cls_alui12, cls_load: begin
                res.src1 = iw.ri12.rj;
                res.dst  = iw.ri12.rd;
            end
            cls_store, cls_branch: begin
                res.src1 = iw.ri12.rj;
                res.src2 = iw.ri12.rd;     // rd is read, not written
            end
            default: ;
        endcase
    end

    assign info.valid = slot.valid;
    assign info.info  = res;

endmodule

`default_nettype wire

// ==== hdl/fetch_buffer.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_buffer
    import fetch_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 flush,
    input  wire logic                 icache_valid,
    input  wire logic                 pair,
    input  wire logic [31:0]          pc,
    input  wire logic [63:0]          irin,
    input  wire logic [1:0]           plv,
    input  wire logic [`PRED_W-1:0]   pred,
    input  wire logic [`EXCP_W-1:0]   excp,
    input  wire logic                 take0,
    input  wire logic                 take1,
    output logic                      full,
    fb_slot_if.producer               slot0,
    fb_slot_if.producer               slot1
);

    fb_entry_t mem [`FB_DEPTH];

    logic [`FB_PTR_W-1:0] head;
    logic [`FB_PTR_W-1:0] tail;
    logic [`FB_CNT_W-1:0] count;

    logic [`FB_PTR_W-1:0] head_p1;
    logic [`FB_PTR_W-1:0] tail_p1;
    logic [1:0]           n_push;
    logic [1:0]           n_pop;
    logic [`FB_CNT_W-1:0] count_nx;
    logic                 push_ok;
    fb_entry_t            entry_a;
    fb_entry_t            entry_b;

    assign entry_a = '{pc: pc, instr: irin[31:0], plv: plv, pred: pred, excp: excp};
    // The second word of a pair follows in memory and never carries the exception
    assign entry_b = '{pc: pc + 32'd4, instr: irin[63:32], plv: plv, pred: pred, excp: '0};

    assign head_p1 = head + 1'b1;
    assign tail_p1 = tail + 1'b1;

    always_comb begin
        n_push = 2'd0;
        if (icache_valid) begin
            n_push = pair ? 2'd2 : 2'd1;
        end
    end

    // take1 never rises without take0
    assign n_pop = {1'b0, take0} + {1'b0, take1};

    // An overflowing strobe is dropped whole
    assign push_ok = icache_valid &&
                     (count + {{(`FB_CNT_W-2){1'b0}}, n_push} <= `FB_CNT_W'(`FB_DEPTH));

    assign count_nx = count
                    + (push_ok ? {{(`FB_CNT_W-2){1'b0}}, n_push} : '0)
                    - {{(`FB_CNT_W-2){1'b0}}, n_pop};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + {{(`FB_PTR_W-2){1'b0}}, n_pop};
            count <= count_nx;
            if (push_ok) begin
                tail <= tail + {{(`FB_PTR_W-2){1'b0}}, n_push};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[tail] <= entry_a;
            if (pair) begin
                mem[tail_p1] <= entry_b;
            end
        end
    end

    assign slot0.valid = (count != '0);
    assign slot0.entry = mem[head];
    assign slot1.valid = (count > `FB_CNT_W'(1));
    assign slot1.entry = mem[head_p1];

    assign full = (count >= `FB_CNT_W'(`FB_FULL_LEVEL));

endmodule

`default_nettype wire

// ==== hdl/fetch_if.sv ====
`default_nettype none

// One presented buffer entry
interface fb_slot_if
    import fetch_pkg::*;
();
    logic      valid;
    fb_entry_t entry;

    modport producer (
        output valid,
        output entry
    );

    modport consumer (
        input valid,
        input entry
    );
endinterface

// Predecode result of one lane
interface lane_info_if
    import decode_pkg::*;
();
    logic       valid;
    lane_info_t info;

    modport producer (
        output valid,
        output info
    );

    modport consumer (
        input valid,
        input info
    );
endinterface

`default_nettype wire

// ==== hdl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_fmt_t;

    // Same 32-bit word, two field layouts
    typedef union packed {
        r3_fmt_t   r3;
        ri12_fmt_t ri12;
    } instr_word_u;

    typedef enum logic [2:0] {
        cls_alu3r,
        cls_alui12,
        cls_load,
        cls_store,
        cls_branch,
        cls_priv,
        cls_other
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        logic [4:0]   src1;
        logic [4:0]   src2;
        logic [4:0]   dst;      // Zero means no register write
        logic         has_excp;
    } lane_info_t;

    // Opcode table, widths follow the bits each format compares
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [9:0]  op_addi_w = 10'h00a;
    localparam logic [9:0]  op_ld_w   = 10'h0a2;
    localparam logic [9:0]  op_st_w   = 10'h0a6;
    localparam logic [5:0]  op_beq    = 6'h16;   // Top 6 bits only
    localparam logic [7:0]  op_csr    = 8'h04;   // Top 8 bits only

endpackage

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

    // One queued instruction as it came from the cache
    typedef struct packed {
        logic [31:0]          pc;
        logic [31:0]          instr;
        logic [1:0]           plv;    // Privilege level at fetch
        logic [`PRED_W-1:0]   pred;   // Branch prediction word
        logic [`EXCP_W-1:0]   excp;   // Nonzero marks a fetch exception
    } fb_entry_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Buffer geometry
`define FB_DEPTH 16
`define FB_PTR_W 4
`define FB_CNT_W 5

// Payload carried next to each instruction
`define PRED_W 64
`define EXCP_W 16

// Full at 14 so that one more pair still fits
`define FB_FULL_LEVEL 14

`endif
